/* design/execute_memory.sv */
// execute_memory: execute, data cache access and writeback registers of the pipeline
module execute_memory import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    dcache_stall,
    input  word_t   dcache_rdata,
    issue_if.accept iss,
    output logic    dcache_ren,
    output logic    dcache_wen,
    output addr_t   dcache_addr,
    output word_t   dcache_wdata,
    fwd_if.producer fwd
);

    // decode/execute register
    alu_op_e  ex_alu_op;
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_store_data;
    reg_idx_t ex_rd;
    logic     ex_reg_write;
    logic     ex_mem_read;
    logic     ex_mem_write;

    word_t    alu_diff;
    word_t    alu_result;

    // execute/memory fields not needed by decode
    logic     mem_mem_write;
    word_t    mem_store_data;

    // -------------------------------------------------------------------------
    // pipeline registers, all frozen by a data cache stall
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_alu_op         <= alu_none;
            ex_reg_write      <= 1'b0;
            ex_mem_read       <= 1'b0;
            ex_mem_write      <= 1'b0;
            fwd.mem_reg_write <= 1'b0;
            fwd.mem_mem_read  <= 1'b0;
            mem_mem_write     <= 1'b0;
            fwd.wb_reg_write  <= 1'b0;
        end else if (!dcache_stall) begin
            ex_alu_op         <= iss.valid ? iss.alu_op : alu_none;  // bubble
            ex_reg_write      <= iss.valid & iss.reg_write;
            ex_mem_read       <= iss.valid & iss.mem_read;
            ex_mem_write      <= iss.valid & iss.mem_write;
            fwd.mem_reg_write <= ex_reg_write;
            fwd.mem_mem_read  <= ex_mem_read;
            mem_mem_write     <= ex_mem_write;
            fwd.wb_reg_write  <= fwd.mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!dcache_stall) begin
            ex_a           <= iss.operand_a;
            ex_b           <= iss.operand_b;
            ex_store_data  <= iss.store_data;
            ex_rd          <= iss.rd;
            fwd.mem_rd     <= ex_rd;
            fwd.mem_result <= alu_result;
            mem_store_data <= ex_store_data;
            fwd.wb_rd      <= fwd.mem_rd;
            fwd.wb_data    <= fwd.mem_wb_data;
        end
    end

    // -------------------------------------------------------------------------
    // alu
    // -------------------------------------------------------------------------
    assign alu_diff = ex_a - ex_b;

    always_comb begin
        case (ex_alu_op)
            alu_add: alu_result = ex_a + ex_b;
            alu_sub: alu_result = alu_diff;
            alu_and: alu_result = ex_a & ex_b;
            alu_or:  alu_result = ex_a | ex_b;
            alu_xor: alu_result = ex_a ^ ex_b;
            alu_sll: alu_result = ex_a << ex_b[4:0];
            alu_srl: alu_result = ex_a >> ex_b[4:0];
            alu_sra: alu_result = word_t'($signed(ex_a) >>> ex_b[4:0]);
            alu_slt: alu_result = {31'b0, alu_diff[31]};  // sign of a - b
            default: alu_result = '0;
        endcase
    end

    assign fwd.ex_rd        = ex_rd;
    assign fwd.ex_reg_write = ex_reg_write;
    assign fwd.ex_mem_read  = ex_mem_read;
    assign fwd.ex_result    = alu_result;

    // memory stage, cache words are byte reversed
    assign dcache_ren   = fwd.mem_mem_read;
    assign dcache_wen   = mem_mem_write;
    assign dcache_addr  = fwd.mem_result[31:2];
    assign dcache_wdata = byte_swap(mem_store_data);

    assign fwd.mem_wb_data = fwd.mem_mem_read ? byte_swap(dcache_rdata) : fwd.mem_result;

endmodule

/* design/fetch_decode.sv */
// fetch_decode: program counter, fetch/decode register, decoder and branch resolution
module fetch_decode import rv_pkg::*; #(
    parameter addr_t reset_pc = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     icache_stall,
    input  word_t    icache_rdata,
    input  logic     dcache_stall,
    input  logic     stall_id,
    input  word_t    rs1_value,    // already forwarded
    input  word_t    rs2_value,
    output addr_t    icache_addr,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output logic     is_branch,
    output logic     uses_rs2,
    issue_if.issue   iss
);

    addr_t      pc;
    addr_t      id_pc;
    word_t      id_instr;
    logic       hold;
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic       is_r;
    logic       is_i;
    logic       is_load;
    logic       is_store;
    logic       taken;
    alu_op_e    alu_op;
    word_t      imm;
    word_t      target;   // byte address

    // -------------------------------------------------------------------------
    // fetch
    // -------------------------------------------------------------------------
    assign hold = icache_stall | dcache_stall | stall_id;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= reset_pc;
            id_instr <= nop_instr;
        end else if (!hold) begin
            if (taken) begin
                pc       <= target[31:2];
                id_instr <= nop_instr;  // drop the word behind the branch
            end else begin
                pc       <= pc + 1'b1;
                id_instr <= byte_swap(icache_rdata);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            id_pc <= pc;
        end
    end

    assign icache_addr = pc;

    // -------------------------------------------------------------------------
    // decode
    // -------------------------------------------------------------------------
    assign opcode    = id_instr[6:0];
    assign funct3    = id_instr[14:12];
    assign rd        = id_instr[11:7];
    assign rs1       = id_instr[19:15];
    assign rs2       = id_instr[24:20];
    assign is_r      = (opcode == op_r_type);
    assign is_i      = (opcode == op_i_type);
    assign is_load   = (opcode == op_load) && (funct3 == 3'b010);
    assign is_store  = (opcode == op_store) && (funct3 == 3'b010);
    assign is_branch = (opcode == op_branch) && (funct3[2:1] == 2'b00);  // beq, bne
    assign uses_rs2  = is_r | is_store | is_branch;

    always_comb begin
        case (funct3)
            3'b000:  alu_op = (is_r && id_instr[30]) ? alu_sub : alu_add;
            3'b001:  alu_op = is_i ? alu_sll : alu_none;
            3'b010:  alu_op = alu_slt;
            3'b100:  alu_op = alu_xor;
            3'b101:  alu_op = !is_i ? alu_none : (id_instr[30] ? alu_sra : alu_srl);
            3'b110:  alu_op = alu_or;
            3'b111:  alu_op = alu_and;
            default: alu_op = alu_none;
        endcase
        if (is_load || is_store) begin
            alu_op = alu_add;  // address
        end else if (!is_r && !is_i) begin
            alu_op = alu_none;
        end
    end

    always_comb begin
        if (is_store) begin
            imm = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
        end else if (is_branch) begin
            imm = {{19{id_instr[31]}}, id_instr[31], id_instr[7],
                   id_instr[30:25], id_instr[11:8], 1'b0};
        end else begin
            imm = {{20{id_instr[31]}}, id_instr[31:20]};  // shifts use only bits 4:0
        end
    end

    // branch compare on forwarded operands
    assign target = {id_pc, 2'b00} + imm;
    assign taken  = is_branch && (funct3[0] ? (rs1_value != rs2_value)
                                            : (rs1_value == rs2_value));

    // issue, nothing leaves decode while it holds
    assign iss.valid      = !hold;
    assign iss.alu_op     = alu_op;
    assign iss.operand_a  = rs1_value;
    assign iss.operand_b  = is_r ? rs2_value : imm;
    assign iss.store_data = rs2_value;
    assign iss.rd         = rd;
    assign iss.reg_write  = (is_r | is_i | is_load) && (rd != '0);
    assign iss.mem_read   = is_load;
    assign iss.mem_write  = is_store;

endmodule

/* design/fwd_if.sv */
// fwd_if: results and destinations of execute, memory and writeback, back to decode
interface fwd_if import rv_pkg::*; ();

    // execute stage
    reg_idx_t ex_rd;
    logic     ex_reg_write;
    logic     ex_mem_read;
    word_t    ex_result;     // alu output, combinational

    // memory stage
    reg_idx_t mem_rd;
    logic     mem_reg_write;
    logic     mem_mem_read;
    word_t    mem_result;    // registered alu value
    word_t    mem_wb_data;   // load data already swapped for a load

    // writeback stage
    reg_idx_t wb_rd;
    logic     wb_reg_write;
    word_t    wb_data;

    modport producer (output ex_rd, ex_reg_write, ex_mem_read, ex_result,
                      mem_rd, mem_reg_write, mem_mem_read, mem_result, mem_wb_data,
                      wb_rd, wb_reg_write, wb_data);
    modport hazard (input ex_rd, ex_reg_write, ex_mem_read,
                    mem_rd, mem_reg_write, mem_mem_read, wb_rd, wb_reg_write);
    modport regs (input ex_result, mem_wb_data, wb_rd, wb_reg_write, wb_data);

endinterface

/* design/hazard_unit.sv */
// hazard_unit: forward selects for decode, load-use and branch-operand stalls
module hazard_unit import rv_pkg::*; (
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     is_branch,
    input  logic     uses_rs2,
    fwd_if.hazard    fwd,
    output fwd_sel_e sel_a,
    output fwd_sel_e sel_b,
    output logic     stall_id
);

    logic ex_writes;
    logic mem_writes;
    logic wb_writes;
    logic load_use;
    logic branch_wait;

    // writers that really update a register
    assign ex_writes  = fwd.ex_reg_write && (fwd.ex_rd != '0);
    assign mem_writes = fwd.mem_reg_write && (fwd.mem_rd != '0);
    assign wb_writes  = fwd.wb_reg_write && (fwd.wb_rd != '0);

    // youngest writer wins
    function automatic fwd_sel_e pick(input reg_idx_t src);
        if (ex_writes && !fwd.ex_mem_read && (fwd.ex_rd == src)) begin
            return fwd_ex;  // load data is not there yet
        end else if (mem_writes && (fwd.mem_rd == src)) begin
            return fwd_mem;
        end else if (wb_writes && (fwd.wb_rd == src)) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    // does the decoded instruction read this register
    function automatic logic reads(input reg_idx_t wr);
        return (wr == rs1) || (uses_rs2 && (wr == rs2));
    endfunction

    // -------------------------------------------------------------------------
    // selects and stalls
    // -------------------------------------------------------------------------
    always_comb begin
        sel_a    = pick(rs1);
        sel_b    = pick(rs2);
        load_use = ex_writes && fwd.ex_mem_read && reads(fwd.ex_rd);
        // compare sits behind the forward mux, so no alu or cache path into it
        branch_wait = is_branch &&
                      ((ex_writes && !fwd.ex_mem_read && reads(fwd.ex_rd)) ||
                       (mem_writes && fwd.mem_mem_read && reads(fwd.mem_rd)));
    end

    assign stall_id = load_use | branch_wait;

endmodule

/* design/issue_if.sv */
// issue_if: one decoded instruction with its operands, from decode into execute
interface issue_if import rv_pkg::*; ();

    logic     valid;       // low means a bubble enters execute
    alu_op_e  alu_op;
    word_t    operand_a;
    word_t    operand_b;   // rs2 or the immediate
    word_t    store_data;  // rs2 value for sw
    reg_idx_t rd;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;

    modport issue (
        output valid, alu_op, operand_a, operand_b, store_data,
               rd, reg_write, mem_read, mem_write
    );

    modport accept (
        input valid, alu_op, operand_a, operand_b, store_data,
              rd, reg_write, mem_read, mem_write
    );

endinterface

/* design/register_file.sv */
// register_file: 32 x 32-bit integer registers with forwarded read ports
module register_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  fwd_sel_e sel_a,
    input  fwd_sel_e sel_b,
    fwd_if.regs      fwd,
    output word_t    rs1_value,
    output word_t    rs2_value
);

    word_t regs [32];

    // write port, driven by writeback
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (fwd.wb_reg_write && (fwd.wb_rd != '0)) begin
            regs[fwd.wb_rd] <= fwd.wb_data;
        end
    end

    // one read port, value picked by the hazard unit
    function automatic word_t read_port(input fwd_sel_e sel, input reg_idx_t idx);
        case (sel)
            fwd_ex:  return fwd.ex_result;
            fwd_mem: return fwd.mem_wb_data;
            fwd_wb:  return fwd.wb_data;  // same-cycle write is not in the array yet
            default: return (idx == '0) ? '0 : regs[idx];
        endcase
    endfunction

    always_comb begin
        rs1_value = read_port(sel_a, rs1);
        rs2_value = read_port(sel_b, rs2);
    end

endmodule

/* design/riscv_pipeline.sv */
// riscv_pipeline: five-stage rv32i integer pipeline with instruction and data cache ports
module riscv_pipeline import rv_pkg::*; #(
    parameter addr_t reset_pc = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    // instruction cache
    input  logic  icache_stall,
    input  word_t icache_rdata,
    output addr_t icache_addr,
    // data cache
    input  logic  dcache_stall,
    input  word_t dcache_rdata,
    output logic  dcache_ren,
    output logic  dcache_wen,
    output addr_t dcache_addr,
    output word_t dcache_wdata
);

    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     is_branch;
    logic     uses_rs2;
    logic     stall_id;
    fwd_sel_e sel_a;
    fwd_sel_e sel_b;
    word_t    rs1_value;
    word_t    rs2_value;

    fwd_if   fwd_bus ();
    issue_if issue_bus ();

    // -------------------------------------------------------------------------
    // fetch and decode, with the operand sources beside it
    // -------------------------------------------------------------------------
    fetch_decode #(.reset_pc(reset_pc)) fd0 (
        .clk(clk), .rst_n(rst_n),
        .icache_stall(icache_stall), .icache_rdata(icache_rdata),
        .dcache_stall(dcache_stall), .stall_id(stall_id),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .icache_addr(icache_addr), .rs1(rs1), .rs2(rs2),
        .is_branch(is_branch), .uses_rs2(uses_rs2),
        .iss(issue_bus.issue)
    );

    register_file rf0 (
        .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2),
        .sel_a(sel_a), .sel_b(sel_b), .fwd(fwd_bus.regs),
        .rs1_value(rs1_value), .rs2_value(rs2_value)
    );

    hazard_unit hz0 (
        .rs1(rs1), .rs2(rs2), .is_branch(is_branch), .uses_rs2(uses_rs2),
        .fwd(fwd_bus.hazard), .sel_a(sel_a), .sel_b(sel_b), .stall_id(stall_id)
    );

    // execute, memory and writeback
    execute_memory exm0 (
        .clk(clk), .rst_n(rst_n),
        .dcache_stall(dcache_stall), .dcache_rdata(dcache_rdata),
        .iss(issue_bus.accept),
        .dcache_ren(dcache_ren), .dcache_wen(dcache_wen),
        .dcache_addr(dcache_addr), .dcache_wdata(dcache_wdata),
        .fwd(fwd_bus.producer)
    );

endmodule

/* design/rv_pkg.sv */
// rv_pkg: shared word types, rv32i opcodes, alu and forwarding encodings
package rv_pkg;

    // -------------------------------------------------------------------------
    // widths with a meaning
    // -------------------------------------------------------------------------
    typedef logic [31:0] word_t;     // data or instruction word
    typedef logic [29:0] addr_t;     // word address, byte address without bits 1:0
    typedef logic [4:0]  reg_idx_t;  // x0..x31

    // -------------------------------------------------------------------------
    // opcodes of the supported subset
    // -------------------------------------------------------------------------
    localparam logic [6:0] op_r_type = 7'b0110011;
    localparam logic [6:0] op_i_type = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam word_t nop_instr = 32'h0000_0013;  // addi x0, x0, 0

    // alu operation, carried from decode into execute
    typedef enum logic [3:0] {
        alu_none = 4'd0,
        alu_add  = 4'd1,
        alu_sub  = 4'd2,
        alu_and  = 4'd3,
        alu_or   = 4'd4,
        alu_xor  = 4'd5,
        alu_sll  = 4'd6,
        alu_srl  = 4'd7,
        alu_sra  = 4'd8,
        alu_slt  = 4'd9
    } alu_op_e;

    // source of a decode operand
    typedef enum logic [1:0] {
        fwd_none = 2'b00,  // register array
        fwd_ex   = 2'b01,
        fwd_mem  = 2'b10,
        fwd_wb   = 2'b11
    } fwd_sel_e;

    // cache buses carry words with reversed byte order
    function automatic word_t byte_swap(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

/* test/riscv_pipeline_assertions.sv */
// riscv_pipeline_assertions: data cache port rules, bound into the pipeline top level
module riscv_pipeline_assertions import rv_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  dcache_stall,
    input logic  dcache_ren,
    input logic  dcache_wen,
    input addr_t dcache_addr,
    input word_t dcache_wdata
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned violations = 0;

    // a cache access is either a read or a write
    assert property (@(posedge clk) disable iff (!rst_n) !(dcache_ren && dcache_wen))
        else begin
            violations++;
            $error("dcache_ren and dcache_wen are both high");
        end

    // the whole access is held while the cache stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        dcache_stall |=> $stable({dcache_ren, dcache_wen, dcache_addr, dcache_wdata}))
        else begin
            violations++;
            $error("data cache outputs changed during a stall");
        end

    assert property (@(posedge clk) $rose(rst_n) |-> !dcache_ren && !dcache_wen)
        else begin
            violations++;
            $error("data cache access right after reset");
        end

endmodule

/* test/tb_riscv_pipeline.sv */
// tb_riscv_pipeline: runs a program through the pipeline and checks its stores on the cache bus
module tb_riscv_pipeline import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam addr_t reset_pc = 30'h40;  // byte address 0x100
    localparam int    loads_in_prog = 3;  // lw instructions in the program table

    logic  clk = 1'b0;
    logic  rst_n = 1'b0;
    logic  icache_stall = 1'b0;
    logic  dcache_stall = 1'b0;
    word_t icache_rdata;
    word_t dcache_rdata;
    addr_t icache_addr;
    logic  dcache_ren;
    logic  dcache_wen;
    addr_t dcache_addr;
    word_t dcache_wdata;

    word_t       prog [$];
    word_t       dmem [64];      // bus byte order
    logic [61:0] expected [$];   // word address, data in register byte order
    logic [61:0] stores [$];     // committed stores as seen on the bus
    addr_t       fetch_idx;
    integer      seed = 32'h587f;
    int          istall_run = 0;
    int          read_count = 0;
    int          errors = 0;

    riscv_pipeline #(.reset_pc(reset_pc)) dut0 (.*);

    bind riscv_pipeline riscv_pipeline_assertions asrt0 (.*);

    always #4 clk = ~clk;

    function automatic word_t reverse_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // instruction encoders, arguments in assembly order
    function automatic word_t rtype(input logic [2:0] f3, input logic [6:0] f7,
                                    input reg_idx_t rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, op_r_type};
    endfunction

    function automatic word_t itype(input logic [6:0] op, input logic [2:0] f3,
                                    input reg_idx_t rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t stype(input reg_idx_t rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic word_t btype(input logic [2:0] f3, input reg_idx_t rs1, rs2,
                                    input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    // ------------------------------------------------------------------------
    // cache models
    // ------------------------------------------------------------------------
    always_comb begin
        fetch_idx = icache_addr - reset_pc;
        if (fetch_idx < prog.size()) begin
            icache_rdata = reverse_bytes(prog[fetch_idx]);
        end else begin
            icache_rdata = reverse_bytes(nop_instr);  // past the end of the program
        end
    end

    assign dcache_rdata = dmem[dcache_addr[5:0]];

    always @(posedge clk) begin
        if (rst_n && dcache_wen && !dcache_stall) begin
            dmem[dcache_addr[5:0]] <= dcache_wdata;
            stores.push_back({dcache_addr, dcache_wdata});
        end
        if (rst_n && dcache_ren && !dcache_stall) begin
            read_count <= read_count + 1;  // completed read access
        end
    end

    // random stalls, icache stall runs capped at 3 cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            icache_stall <= 1'b0;
            dcache_stall <= 1'b0;
            istall_run   <= 0;
        end else begin
            dcache_stall <= (($random(seed) & 3) == 0);
            if (istall_run < 3 && (($random(seed) & 3) == 0)) begin
                icache_stall <= 1'b1;
                istall_run   <= istall_run + 1;
            end else begin
                icache_stall <= 1'b0;
                istall_run   <= 0;
            end
        end
    end

    initial begin
        logic [61:0] got;
        logic [61:0] want;
        int          wait_cycles;
        bit          timed_out;

        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'hd0d0_0000 | i;
        end
        prog = '{
            itype(op_i_type, 3'b000, 1, 0, 12'hffb),    // addi x1, x0, -5
            itype(op_i_type, 3'b000, 2, 0, 12'h003),    // addi x2, x0, 3
            rtype(3'b000, 7'h00, 3, 1, 2),              // add  x3, x1, x2
            rtype(3'b000, 7'h20, 4, 3, 1),              // sub  x4, x3, x1
            stype(4, 0, 12'h000),                       // sw   x4, 0(x0)
            rtype(3'b010, 7'h00, 5, 1, 2),              // slt  x5, x1, x2
            rtype(3'b100, 7'h00, 6, 1, 5),              // xor  x6, x1, x5
            rtype(3'b110, 7'h00, 7, 6, 2),              // or   x7, x6, x2
            rtype(3'b111, 7'h00, 8, 7, 6),              // and  x8, x7, x6
            stype(8, 0, 12'h004),                       // sw   x8, 4(x0)
            itype(op_i_type, 3'b010, 9, 1, 12'h004),    // slti x9, x1, 4
            itype(op_i_type, 3'b100, 10, 1, 12'h00f),   // xori x10, x1, 15
            itype(op_i_type, 3'b111, 11, 10, 12'h03c),  // andi x11, x10, 0x3c
            itype(op_i_type, 3'b110, 12, 11, 12'h101),  // ori  x12, x11, 0x101
            itype(op_i_type, 3'b001, 13, 12, 12'h004),  // slli x13, x12, 4
            itype(op_i_type, 3'b101, 14, 1, 12'h401),   // srai x14, x1, 1
            itype(op_i_type, 3'b101, 15, 14, 12'h01c),  // srli x15, x14, 28
            rtype(3'b000, 7'h00, 16, 13, 9),            // add  x16, x13, x9
            stype(16, 0, 12'h008),                      // sw   x16, 8(x0)
            stype(15, 0, 12'h00c),                      // sw   x15, 12(x0)
            stype(14, 0, 12'h010),                      // sw   x14, 16(x0)
            itype(op_load, 3'b010, 17, 0, 12'h008),     // lw   x17, 8(x0)
            itype(op_i_type, 3'b000, 18, 17, 12'h001),  // addi x18, x17, 1
            itype(op_load, 3'b010, 19, 0, 12'h000),     // lw   x19, 0(x0)
            stype(19, 0, 12'h014),                      // sw   x19, 20(x0)
            itype(op_load, 3'b010, 20, 0, 12'h004),     // lw   x20, 4(x0)
            stype(18, 0, 12'h018),                      // sw   x18, 24(x0)
            btype(3'b001, 20, 8, 13'h008),              // bne  x20, x8, not taken
            stype(20, 0, 12'h01c),                      // sw   x20, 28(x0)
            itype(op_i_type, 3'b000, 21, 0, 12'h007),   // addi x21, x0, 7
            btype(3'b001, 21, 2, 13'h008),              // bne  x21, x2, taken
            stype(2, 0, 12'h020),                       // skipped
            btype(3'b000, 19, 2, 13'h008),              // beq  x19, x2, taken
            stype(21, 0, 12'h024),                      // skipped
            btype(3'b000, 21, 2, 13'h008),              // beq  x21, x2, not taken
            stype(21, 0, 12'h028),                      // sw   x21, 40(x0)
            btype(3'b000, 0, 0, 13'h000)                // spin here
        };
        expected = '{
            {30'd0, 32'h0000_0003}, {30'd1, 32'hffff_fffa}, {30'd2, 32'h0000_1351},
            {30'd3, 32'h0000_000f}, {30'd4, 32'hffff_fffd}, {30'd5, 32'h0000_0003},
            {30'd6, 32'h0000_1352}, {30'd7, 32'hffff_fffa}, {30'd10, 32'h0000_0007}
        };
        timed_out = 1'b0;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (icache_addr == reset_pc) else begin
            errors++;
            $display("FAILED icache_addr expected %h got %h", reset_pc, icache_addr);
        end

        // one committed store per table entry, in order
        for (int n = 0; n < expected.size() && !timed_out; n++) begin
            wait_cycles = 0;
            while (stores.size() == 0 && wait_cycles < 200) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (stores.size() == 0) begin
                errors++;
                timed_out = 1'b1;
                $display("no store committed within 200 cycles for entry %0d", n);
            end else begin
                got  = stores.pop_front();
                want = expected[n];
                assert (got[61:32] == want[61:32]) else begin
                    errors++;
                    $display("FAILED dcache_addr expected %h got %h", want[61:32], got[61:32]);
                end
                assert (got[31:0] == reverse_bytes(want[31:0])) else begin
                    errors++;
                    $display("FAILED dcache_wdata expected %h got %h",
                             reverse_bytes(want[31:0]), got[31:0]);
                end
            end
        end

        // the spin loop must not store anything
        if (!timed_out) begin
            repeat (50) begin
                @(negedge clk);
                assert (stores.size() == 0) else begin
                    errors++;
                    $display("store to word %h after the last expected store", stores[0][61:32]);
                    stores.delete();
                end
            end
            // each lw reads the cache exactly once, nothing else reads it
            assert (read_count == loads_in_prog) else begin
                errors++;
                $display("FAILED dcache_ren read count expected %h got %h",
                         loads_in_prog, read_count);
            end
        end

        errors += dut0.asrt0.violations;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/rv_pkg.sv
design/fwd_if.sv
design/issue_if.sv
design/fetch_decode.sv
design/register_file.sv
design/hazard_unit.sv
design/execute_memory.sv
design/riscv_pipeline.sv
test/riscv_pipeline_assertions.sv
test/tb_riscv_pipeline.sv
